/* rtl/int_core_pkg.sv */
package int_core_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int XLEN      = 32;
    localparam int PHYS_REGS = 64;
    localparam int PHYS_IDX  = 6;
    localparam int ROB_IDX   = 5;

    // lane 0 is the ALU, lane 1 the external producer
    localparam int CDB_WIDTH = 2;

    ////////////////////////////////////////////////////////////
    // micro-op encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic [1:0] {
        OP2_RS2,
        OP2_IMM,
        OP2_ZERO
    } op2_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_MUL
    } alu_op_e;

    // alu control
    typedef enum logic [0:0] {
        ALU_IDLE,
        ALU_MUL_BUSY
    } alu_state_e;

endpackage

/* rtl/int_rs.sv */
`timescale 1ns/100ps

module int_rs #(
    parameter int RS_DEPTH = 8
) (
    input  logic                               clk,
    input  logic                               rst,

    input  logic                               ds_valid,
    output logic                               ds_ready,
    input  logic [int_core_pkg::ROB_IDX-1:0]   ds_rob_id,
    input  logic [int_core_pkg::PHYS_IDX-1:0]  ds_rd_phy,
    input  logic [int_core_pkg::PHYS_IDX-1:0]  ds_rs1_phy,
    input  logic [int_core_pkg::PHYS_IDX-1:0]  ds_rs2_phy,
    input  logic                               ds_rs1_ready,
    input  logic                               ds_rs2_ready,
    input  int_core_pkg::op1_sel_e             ds_op1_sel,
    input  int_core_pkg::op2_sel_e             ds_op2_sel,
    input  int_core_pkg::alu_op_e              ds_alu_op,
    input  logic [int_core_pkg::XLEN-1:0]      ds_imm,
    input  logic [int_core_pkg::XLEN-1:0]      ds_pc,

    input  logic                               cdb_valid  [int_core_pkg::CDB_WIDTH],
    input  logic [int_core_pkg::PHYS_IDX-1:0]  cdb_rd_phy [int_core_pkg::CDB_WIDTH],

    output logic [int_core_pkg::PHYS_IDX-1:0]  rd_addr1,
    output logic [int_core_pkg::PHYS_IDX-1:0]  rd_addr2,

    output logic                               iss_valid,
    input  logic                               iss_ready,
    output logic [int_core_pkg::ROB_IDX-1:0]   iss_rob_id,
    output logic [int_core_pkg::PHYS_IDX-1:0]  iss_rd_phy,
    output int_core_pkg::op1_sel_e             iss_op1_sel,
    output int_core_pkg::op2_sel_e             iss_op2_sel,
    output int_core_pkg::alu_op_e              iss_alu_op,
    output logic [int_core_pkg::XLEN-1:0]      iss_imm,
    output logic [int_core_pkg::XLEN-1:0]      iss_pc
);
    import int_core_pkg::*;

    localparam int RS_IDX = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    ////////////////////////////////////////////////////////////
    // entry array
    ////////////////////////////////////////////////////////////

    logic [RS_DEPTH-1:0] entry_valid;
    logic [RS_DEPTH-1:0] entry_ready;

    logic [ROB_IDX-1:0]  ent_rob_id  [RS_DEPTH];
    logic [PHYS_IDX-1:0] ent_rd_phy  [RS_DEPTH];
    logic [PHYS_IDX-1:0] ent_rs1_phy [RS_DEPTH];
    logic [PHYS_IDX-1:0] ent_rs2_phy [RS_DEPTH];
    logic                ent_rs1_rdy [RS_DEPTH];
    logic                ent_rs2_rdy [RS_DEPTH];
    op1_sel_e            ent_op1_sel [RS_DEPTH];
    op2_sel_e            ent_op2_sel [RS_DEPTH];
    alu_op_e             ent_alu_op  [RS_DEPTH];
    logic [XLEN-1:0]     ent_imm     [RS_DEPTH];
    logic [XLEN-1:0]     ent_pc      [RS_DEPTH];

    logic              push_fire;
    logic              push_found;
    logic [RS_IDX-1:0] push_idx;
    logic              push_hit1;
    logic              push_hit2;
    logic              issue_fire;
    logic              issue_found;
    logic [RS_IDX-1:0] issue_idx;

    assign ds_ready  = ~&entry_valid;
    assign push_fire = ds_valid && ds_ready && push_found;

    // lowest free slot, from occupancy at the start of the cycle
    always_comb begin
        push_found = 1'b0;
        push_idx   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!entry_valid[i] && !push_found) begin
                push_found = 1'b1;
                push_idx   = RS_IDX'(i);
            end
        end
    end

    // a tag broadcast while the uop is being pushed
    always_comb begin
        push_hit1 = 1'b0;
        push_hit2 = 1'b0;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (cdb_valid[k] && cdb_rd_phy[k] == ds_rs1_phy) push_hit1 = 1'b1;
            if (cdb_valid[k] && cdb_rd_phy[k] == ds_rs2_phy) push_hit2 = 1'b1;
        end
    end

    // per-entry readiness including this cycle's CDB
    always_comb begin
        logic src1_ok;
        logic src2_ok;
        for (int i = 0; i < RS_DEPTH; i++) begin
            src1_ok = ent_rs1_rdy[i] || (ent_op1_sel[i] != OP1_RS1);
            src2_ok = ent_rs2_rdy[i] || (ent_op2_sel[i] != OP2_RS2);
            for (int k = 0; k < CDB_WIDTH; k++) begin
                if (cdb_valid[k] && cdb_rd_phy[k] == ent_rs1_phy[i]) src1_ok = 1'b1;
                if (cdb_valid[k] && cdb_rd_phy[k] == ent_rs2_phy[i]) src2_ok = 1'b1;
            end
            entry_ready[i] = entry_valid[i] && src1_ok && src2_ok;
        end
    end

    // lowest ready entry wins
    always_comb begin
        issue_found = 1'b0;
        issue_idx   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (entry_ready[i] && !issue_found) begin
                issue_found = 1'b1;
                issue_idx   = RS_IDX'(i);
            end
        end
    end

    assign issue_fire = issue_found && iss_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else begin
            if (issue_fire) begin
                entry_valid[issue_idx] <= 1'b0;
            end
            if (push_fire) begin
                entry_valid[push_idx] <= 1'b1;
            end
        end
    end

    // wakeup first, push overrides the free slot it lands in
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int k = 0; k < CDB_WIDTH; k++) begin
                if (cdb_valid[k] && cdb_rd_phy[k] == ent_rs1_phy[i]) ent_rs1_rdy[i] <= 1'b1;
                if (cdb_valid[k] && cdb_rd_phy[k] == ent_rs2_phy[i]) ent_rs2_rdy[i] <= 1'b1;
            end
        end
        if (push_fire) begin
            ent_rob_id[push_idx]  <= ds_rob_id;
            ent_rd_phy[push_idx]  <= ds_rd_phy;
            ent_rs1_phy[push_idx] <= ds_rs1_phy;
            ent_rs2_phy[push_idx] <= ds_rs2_phy;
            ent_rs1_rdy[push_idx] <= ds_rs1_ready || push_hit1;
            ent_rs2_rdy[push_idx] <= ds_rs2_ready || push_hit2;
            ent_op1_sel[push_idx] <= ds_op1_sel;
            ent_op2_sel[push_idx] <= ds_op2_sel;
            ent_alu_op[push_idx]  <= ds_alu_op;
            ent_imm[push_idx]     <= ds_imm;
            ent_pc[push_idx]      <= ds_pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // issue port
    ////////////////////////////////////////////////////////////

    assign rd_addr1    = ent_rs1_phy[issue_idx];
    assign rd_addr2    = ent_rs2_phy[issue_idx];

    assign iss_valid   = issue_found;
    assign iss_rob_id  = ent_rob_id[issue_idx];
    assign iss_rd_phy  = ent_rd_phy[issue_idx];
    assign iss_op1_sel = ent_op1_sel[issue_idx];
    assign iss_op2_sel = ent_op2_sel[issue_idx];
    assign iss_alu_op  = ent_alu_op[issue_idx];
    assign iss_imm     = ent_imm[issue_idx];
    assign iss_pc      = ent_pc[issue_idx];

endmodule

/* rtl/phys_reg_file.sv */
`timescale 1ns/100ps

module phys_reg_file (
    input  logic                               clk,
    input  logic                               rst,

    input  logic                               wr_valid [int_core_pkg::CDB_WIDTH],
    input  logic [int_core_pkg::PHYS_IDX-1:0]  wr_phy   [int_core_pkg::CDB_WIDTH],
    input  logic [int_core_pkg::XLEN-1:0]      wr_value [int_core_pkg::CDB_WIDTH],

    input  logic [int_core_pkg::PHYS_IDX-1:0]  rd_addr1,
    input  logic [int_core_pkg::PHYS_IDX-1:0]  rd_addr2,
    output logic [int_core_pkg::XLEN-1:0]      rd_data1,
    output logic [int_core_pkg::XLEN-1:0]      rd_data2
);
    import int_core_pkg::*;

    logic [XLEN-1:0] regs [PHYS_REGS];

    // lane 0 is applied last so it wins a same-register clash
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int k = CDB_WIDTH - 1; k >= 0; k--) begin
                if (wr_valid[k] && wr_phy[k] != '0) begin
                    regs[wr_phy[k]] <= wr_value[k];
                end
            end
        end
    end

    // same-cycle bypass, p0 hardwired to zero
    function automatic logic [XLEN-1:0] read_port(input logic [PHYS_IDX-1:0] addr);
        logic [XLEN-1:0] data;
        data = regs[addr];
        for (int k = CDB_WIDTH - 1; k >= 0; k--) begin
            if (wr_valid[k] && wr_phy[k] == addr) data = wr_value[k];
        end
        if (addr == '0) data = '0;
        return data;
    endfunction

    always_comb begin
        rd_data1 = read_port(rd_addr1);
        rd_data2 = read_port(rd_addr2);
    end

endmodule

/* rtl/fu_alu.sv */
`timescale 1ns/100ps

module fu_alu #(
    parameter int MUL_STEP_BITS = 2
) (
    input  logic                               clk,
    input  logic                               rst,

    input  logic                               iss_valid,
    output logic                               iss_ready,
    input  logic [int_core_pkg::ROB_IDX-1:0]   iss_rob_id,
    input  logic [int_core_pkg::PHYS_IDX-1:0]  iss_rd_phy,
    input  int_core_pkg::op1_sel_e             iss_op1_sel,
    input  int_core_pkg::op2_sel_e             iss_op2_sel,
    input  int_core_pkg::alu_op_e              iss_alu_op,
    input  logic [int_core_pkg::XLEN-1:0]      iss_imm,
    input  logic [int_core_pkg::XLEN-1:0]      iss_pc,
    input  logic [int_core_pkg::XLEN-1:0]      rs1_value,
    input  logic [int_core_pkg::XLEN-1:0]      rs2_value,

    output logic                               cdb0_valid,
    output logic [int_core_pkg::ROB_IDX-1:0]   cdb0_rob_id,
    output logic [int_core_pkg::PHYS_IDX-1:0]  cdb0_rd_phy,
    output logic [int_core_pkg::XLEN-1:0]      cdb0_value
);
    import int_core_pkg::*;

    localparam int MUL_CYCLES = XLEN / MUL_STEP_BITS;
    localparam int CNT_W      = (MUL_CYCLES > 1) ? $clog2(MUL_CYCLES) : 1;

    alu_state_e       state;
    logic [CNT_W-1:0] mul_cnt;
    logic [XLEN-1:0]  op1;
    logic [XLEN-1:0]  op2;
    logic [XLEN-1:0]  simple_result;
    logic [XLEN-1:0]  mul_acc;
    logic [XLEN-1:0]  mul_acc_next;
    logic [XLEN-1:0]  mul_mcand;
    logic [XLEN-1:0]  mul_mplier;
    logic             issue_fire;
    logic             mul_last;

    assign iss_ready  = (state == ALU_IDLE);
    assign issue_fire = iss_valid && iss_ready;
    assign mul_last   = (state == ALU_MUL_BUSY) && (mul_cnt == CNT_W'(MUL_CYCLES - 1));

    ////////////////////////////////////////////////////////////
    // operands and single-cycle ops
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (iss_op1_sel)
            OP1_RS1: op1 = rs1_value;
            OP1_PC:  op1 = iss_pc;
            default: op1 = '0;
        endcase
        case (iss_op2_sel)
            OP2_RS2: op2 = rs2_value;
            OP2_IMM: op2 = iss_imm;
            default: op2 = '0;
        endcase
    end

    always_comb begin
        case (iss_alu_op)
            ALU_ADD: simple_result = op1 + op2;
            ALU_SUB: simple_result = op1 - op2;
            ALU_AND: simple_result = op1 & op2;
            ALU_OR:  simple_result = op1 | op2;
            ALU_XOR: simple_result = op1 ^ op2;
            ALU_SLL: simple_result = op1 << op2[4:0];
            ALU_SRL: simple_result = op1 >> op2[4:0];
            ALU_SLT: simple_result = XLEN'($signed(op1) < $signed(op2));
            default: simple_result = '0;
        endcase
    end

    // one shift-add step over the low multiplier bits
    always_comb begin
        mul_acc_next = mul_acc;
        for (int j = 0; j < MUL_STEP_BITS; j++) begin
            if (mul_mplier[j]) mul_acc_next = mul_acc_next + (mul_mcand << j);
        end
    end

    ////////////////////////////////////////////////////////////
    // control FSM and step counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ALU_IDLE;
            mul_cnt    <= '0;
            cdb0_valid <= 1'b0;
        end else begin
            cdb0_valid <= 1'b0;
            case (state)
                ALU_IDLE: begin
                    if (issue_fire) begin
                        if (iss_alu_op == ALU_MUL) begin
                            state   <= ALU_MUL_BUSY;
                            mul_cnt <= '0;
                        end else begin
                            cdb0_valid <= 1'b1;
                        end
                    end
                end
                default: begin
                    mul_cnt <= mul_cnt + 1'b1;
                    if (mul_last) begin
                        state      <= ALU_IDLE;
                        cdb0_valid <= 1'b1;
                    end
                end
            endcase
        end
    end

    // tags and multiply operands captured on issue
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            cdb0_rob_id <= iss_rob_id;
            cdb0_rd_phy <= iss_rd_phy;
            cdb0_value  <= simple_result;
            mul_acc     <= '0;
            mul_mcand   <= op1;
            mul_mplier  <= op2;
        end
        if (state == ALU_MUL_BUSY) begin
            mul_acc    <= mul_acc_next;
            mul_mcand  <= mul_mcand << MUL_STEP_BITS;
            mul_mplier <= mul_mplier >> MUL_STEP_BITS;
            if (mul_last) begin
                cdb0_value <= mul_acc_next;
            end
        end
    end

endmodule

/* rtl/int_exec_top.sv */
`timescale 1ns/100ps

module int_exec_top #(
    parameter int RS_DEPTH      = 8,
    parameter int MUL_STEP_BITS = 2
) (
    input  logic                               clk,
    input  logic                               rst,

    input  logic                               ds_valid,
    output logic                               ds_ready,
    input  logic [int_core_pkg::ROB_IDX-1:0]   ds_rob_id,
    input  logic [int_core_pkg::PHYS_IDX-1:0]  ds_rd_phy,
    input  logic [int_core_pkg::PHYS_IDX-1:0]  ds_rs1_phy,
    input  logic [int_core_pkg::PHYS_IDX-1:0]  ds_rs2_phy,
    input  logic                               ds_rs1_ready,
    input  logic                               ds_rs2_ready,
    input  int_core_pkg::op1_sel_e             ds_op1_sel,
    input  int_core_pkg::op2_sel_e             ds_op2_sel,
    input  int_core_pkg::alu_op_e              ds_alu_op,
    input  logic [int_core_pkg::XLEN-1:0]      ds_imm,
    input  logic [int_core_pkg::XLEN-1:0]      ds_pc,

    input  logic                               ext_wr_valid,
    input  logic [int_core_pkg::PHYS_IDX-1:0]  ext_wr_phy,
    input  logic [int_core_pkg::XLEN-1:0]      ext_wr_value,

    output logic                               cdb0_valid,
    output logic [int_core_pkg::ROB_IDX-1:0]   cdb0_rob_id,
    output logic [int_core_pkg::PHYS_IDX-1:0]  cdb0_rd_phy,
    output logic [int_core_pkg::XLEN-1:0]      cdb0_value
);
    import int_core_pkg::*;

    logic                cdb_valid  [CDB_WIDTH];
    logic [PHYS_IDX-1:0] cdb_rd_phy [CDB_WIDTH];
    logic [XLEN-1:0]     cdb_value  [CDB_WIDTH];

    logic [PHYS_IDX-1:0] rd_addr1;
    logic [PHYS_IDX-1:0] rd_addr2;
    logic [XLEN-1:0]     rd_data1;
    logic [XLEN-1:0]     rd_data2;

    logic                iss_valid;
    logic                iss_ready;
    logic [ROB_IDX-1:0]  iss_rob_id;
    logic [PHYS_IDX-1:0] iss_rd_phy;
    op1_sel_e            iss_op1_sel;
    op2_sel_e            iss_op2_sel;
    alu_op_e             iss_alu_op;
    logic [XLEN-1:0]     iss_imm;
    logic [XLEN-1:0]     iss_pc;

    // lane 0 from the ALU, lane 1 from the load stand-in
    assign cdb_valid[0]  = cdb0_valid;
    assign cdb_rd_phy[0] = cdb0_rd_phy;
    assign cdb_value[0]  = cdb0_value;
    assign cdb_valid[1]  = ext_wr_valid;
    assign cdb_rd_phy[1] = ext_wr_phy;
    assign cdb_value[1]  = ext_wr_value;

    int_rs #(
        .RS_DEPTH (RS_DEPTH)
    ) u_int_rs (
        .clk          (clk),
        .rst          (rst),
        .ds_valid     (ds_valid),
        .ds_ready     (ds_ready),
        .ds_rob_id    (ds_rob_id),
        .ds_rd_phy    (ds_rd_phy),
        .ds_rs1_phy   (ds_rs1_phy),
        .ds_rs2_phy   (ds_rs2_phy),
        .ds_rs1_ready (ds_rs1_ready),
        .ds_rs2_ready (ds_rs2_ready),
        .ds_op1_sel   (ds_op1_sel),
        .ds_op2_sel   (ds_op2_sel),
        .ds_alu_op    (ds_alu_op),
        .ds_imm       (ds_imm),
        .ds_pc        (ds_pc),
        .cdb_valid    (cdb_valid),
        .cdb_rd_phy   (cdb_rd_phy),
        .rd_addr1     (rd_addr1),
        .rd_addr2     (rd_addr2),
        .iss_valid    (iss_valid),
        .iss_ready    (iss_ready),
        .iss_rob_id   (iss_rob_id),
        .iss_rd_phy   (iss_rd_phy),
        .iss_op1_sel  (iss_op1_sel),
        .iss_op2_sel  (iss_op2_sel),
        .iss_alu_op   (iss_alu_op),
        .iss_imm      (iss_imm),
        .iss_pc       (iss_pc)
    );

    phys_reg_file u_phys_reg_file (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (cdb_valid),
        .wr_phy   (cdb_rd_phy),
        .wr_value (cdb_value),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    fu_alu #(
        .MUL_STEP_BITS (MUL_STEP_BITS)
    ) u_fu_alu (
        .clk         (clk),
        .rst         (rst),
        .iss_valid   (iss_valid),
        .iss_ready   (iss_ready),
        .iss_rob_id  (iss_rob_id),
        .iss_rd_phy  (iss_rd_phy),
        .iss_op1_sel (iss_op1_sel),
        .iss_op2_sel (iss_op2_sel),
        .iss_alu_op  (iss_alu_op),
        .iss_imm     (iss_imm),
        .iss_pc      (iss_pc),
        .rs1_value   (rd_data1),
        .rs2_value   (rd_data2),
        .cdb0_valid  (cdb0_valid),
        .cdb0_rob_id (cdb0_rob_id),
        .cdb0_rd_phy (cdb0_rd_phy),
        .cdb0_value  (cdb0_value)
    );

endmodule

/* sim/int_exec_properties.sv */
`timescale 1ns/100ps

module int_exec_properties #(
    parameter int RS_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ds_valid,
    input  logic                     ds_ready,
    input  logic                     iss_valid,
    input  logic                     iss_ready,
    input  logic                     cdb0_valid,
    input  int_core_pkg::alu_state_e alu_state
);
    import int_core_pkg::*;

    localparam int OCC_W = $clog2(RS_DEPTH + 1);

    logic             pending;
    logic [4:0]       age;
    logic [OCC_W-1:0] occupancy;
    int               assert_failures = 0;

    // cycles since the last issue still waiting for its result
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            age     <= '0;
        end else if (iss_valid && iss_ready) begin
            pending <= 1'b1;
            age     <= '0;
        end else if (cdb0_valid) begin
            pending <= 1'b0;
        end else if (pending) begin
            age <= age + 1'b1;
        end
    end

    // station occupancy from the handshakes alone
    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + OCC_W'(ds_valid && ds_ready)
                                   - OCC_W'(iss_valid && iss_ready);
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !iss_valid && !cdb0_valid)
        else begin
            assert_failures++;
            $error("issue or result valid right after reset");
        end

    a_busy_holds_issue: assert property (@(posedge clk) disable iff (rst)
        (alu_state == ALU_MUL_BUSY) && iss_valid |=> iss_valid)
        else begin
            assert_failures++;
            $error("offered uop withdrawn while the ALU multiplies");
        end

    a_full_station: assert property (@(posedge clk) disable iff (rst)
        (occupancy == OCC_W'(RS_DEPTH)) == !ds_ready)
        else begin
            assert_failures++;
            $error("ds_ready disagrees with station occupancy");
        end

    a_result_latency: assert property (@(posedge clk) disable iff (rst)
        pending |-> age < 5'd17)
        else begin
            assert_failures++;
            $error("no result within 17 cycles of issue");
        end

endmodule

// reaches into the ALU FSM
bind int_exec_top int_exec_properties #(
    .RS_DEPTH (RS_DEPTH)
) u_int_exec_properties (
    .clk        (clk),
    .rst        (rst),
    .ds_valid   (ds_valid),
    .ds_ready   (ds_ready),
    .iss_valid  (iss_valid),
    .iss_ready  (iss_ready),
    .cdb0_valid (cdb0_valid),
    .alu_state  (u_fu_alu.state)
);

/* sim/int_exec_tb.sv */
`timescale 1ns/100ps

module int_exec_tb;
    import int_core_pkg::*;

    localparam int NUM_UOPS = 40;
    localparam int RD_BASE  = 24;
    localparam int WAIT_MAX = 2000;

    logic                clk;
    logic                rst;
    logic                ds_valid;
    logic                ds_ready;
    logic [ROB_IDX-1:0]  ds_rob_id;
    logic [PHYS_IDX-1:0] ds_rd_phy;
    logic [PHYS_IDX-1:0] ds_rs1_phy;
    logic [PHYS_IDX-1:0] ds_rs2_phy;
    logic                ds_rs1_ready;
    logic                ds_rs2_ready;
    op1_sel_e            ds_op1_sel;
    op2_sel_e            ds_op2_sel;
    alu_op_e             ds_alu_op;
    logic [XLEN-1:0]     ds_imm;
    logic [XLEN-1:0]     ds_pc;
    logic                ext_wr_valid;
    logic [PHYS_IDX-1:0] ext_wr_phy;
    logic [XLEN-1:0]     ext_wr_value;
    logic                cdb0_valid;
    logic [ROB_IDX-1:0]  cdb0_rob_id;
    logic [PHYS_IDX-1:0] cdb0_rd_phy;
    logic [XLEN-1:0]     cdb0_value;

    // program and reference model
    logic [31:0]         rng_state;
    logic [XLEN-1:0]     model_reg [PHYS_REGS];
    logic                written   [PHYS_REGS];
    logic                done      [NUM_UOPS];
    op1_sel_e            u_op1     [NUM_UOPS];
    op2_sel_e            u_op2     [NUM_UOPS];
    alu_op_e             u_op      [NUM_UOPS];
    logic [PHYS_IDX-1:0] u_rs1     [NUM_UOPS];
    logic [PHYS_IDX-1:0] u_rs2     [NUM_UOPS];
    logic [XLEN-1:0]     u_imm     [NUM_UOPS];
    logic [XLEN-1:0]     u_pc      [NUM_UOPS];
    int                  result_errors;
    int                  other_errors;
    int                  done_count;
    int                  full_cycles;
    logic                timed_out;

    int_exec_top #(
        .RS_DEPTH      (8),
        .MUL_STEP_BITS (2)
    ) u_int_exec_top (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // random numbers and reference ALU
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [XLEN-1:0] expected_result(input alu_op_e op,
                                                         input logic [XLEN-1:0] a,
                                                         input logic [XLEN-1:0] b);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_MUL: return prod[31:0];
            default: return '0;
        endcase
    endfunction

    // early register, late register or an earlier result
    function automatic logic [PHYS_IDX-1:0] pick_reg(input int n);
        logic [31:0] r;
        r = next_rand() % 32'd4;
        if (r == 32'd0 || n == 0) return PHYS_IDX'(next_rand() % 32'd16);
        if (r == 32'd1) return PHYS_IDX'(32'd16 + next_rand() % 32'd8);
        return PHYS_IDX'(RD_BASE + (next_rand() % n));
    endfunction

    task automatic build_program();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (int n = 0; n < NUM_UOPS; n++) begin
            u_rs1[n] = pick_reg(n);
            u_rs2[n] = pick_reg(n);
            u_op1[n] = op1_sel_e'(2'(next_rand() % 32'd3));
            u_op2[n] = op2_sel_e'(2'(next_rand() % 32'd3));
            u_op[n]  = alu_op_e'(4'(next_rand() % 32'd9));
            u_imm[n] = next_rand();
            u_pc[n]  = 32'h0000_1000 + 32'(4 * n);
            // head of the program waits on p16 so the station fills
            if (n < 10) begin
                u_rs1[n] = 6'd16;
                u_op1[n] = OP1_RS1;
            end
            a = (u_op1[n] == OP1_RS1) ? model_reg[u_rs1[n]] :
                (u_op1[n] == OP1_PC)  ? u_pc[n] : '0;
            b = (u_op2[n] == OP2_RS2) ? model_reg[u_rs2[n]] :
                (u_op2[n] == OP2_IMM) ? u_imm[n] : '0;
            model_reg[RD_BASE + n] = expected_result(u_op[n], a, b);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // drivers
    ////////////////////////////////////////////////////////////

    task automatic ext_write(input logic [PHYS_IDX-1:0] p);
        ext_wr_valid = 1'b1;
        ext_wr_phy   = p;
        ext_wr_value = model_reg[p];
        @(posedge clk);
        #2;
        ext_wr_valid = 1'b0;
    endtask

    task automatic late_writes();
        int gap;
        for (int p = 16; p < 24; p++) begin
            gap = (p == 16) ? 40 + int'(next_rand() % 32'd16) : 4 + int'(next_rand() % 32'd24);
            repeat (gap) @(posedge clk);
            #2;
            ext_write(PHYS_IDX'(p));
        end
    endtask

    // ready bits refreshed every cycle while held
    task automatic dispatch_uop(input int n);
        int waited;
        waited       = 0;
        ds_valid     = 1'b1;
        ds_rob_id    = ROB_IDX'(n);
        ds_rd_phy    = PHYS_IDX'(RD_BASE + n);
        ds_rs1_phy   = u_rs1[n];
        ds_rs2_phy   = u_rs2[n];
        ds_op1_sel   = u_op1[n];
        ds_op2_sel   = u_op2[n];
        ds_alu_op    = u_op[n];
        ds_imm       = u_imm[n];
        ds_pc        = u_pc[n];
        ds_rs1_ready = written[u_rs1[n]];
        ds_rs2_ready = written[u_rs2[n]];
        @(negedge clk);
        while (!ds_ready && !timed_out) begin
            waited++;
            if (waited > WAIT_MAX) begin
                $display("timeout: dispatch of uop %0d was never accepted", n);
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
                #2;
                ds_rs1_ready = written[u_rs1[n]];
                ds_rs2_ready = written[u_rs2[n]];
                @(negedge clk);
            end
        end
        @(posedge clk);
        #2;
        ds_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // result monitor
    ////////////////////////////////////////////////////////////

    task automatic check_result();
        int n;
        n = int'(cdb0_rd_phy) - RD_BASE;
        if (n < 0 || n >= NUM_UOPS) begin
            $display("%0t result broadcast for unexpected register p%0d", $time, cdb0_rd_phy);
            result_errors++;
        end else if (done[n]) begin
            $display("%0t uop %0d completed a second time", $time, n);
            result_errors++;
        end else begin
            if (cdb0_rob_id !== ROB_IDX'(n)) begin
                $display("[ERROR] %0t cdb0_rob_id: expected %0d, got %0d",
                         $time, ROB_IDX'(n), cdb0_rob_id);
                result_errors++;
            end
            if (cdb0_value !== model_reg[cdb0_rd_phy]) begin
                $display("[ERROR] %0t cdb0_value: expected %h, got %h",
                         $time, model_reg[cdb0_rd_phy], cdb0_value);
                result_errors++;
            end
            if ((u_op1[n] == OP1_RS1 && !written[u_rs1[n]]) ||
                (u_op2[n] == OP2_RS2 && !written[u_rs2[n]])) begin
                $display("%0t uop %0d completed before its sources were written", $time, n);
                result_errors++;
            end
            done[n] = 1'b1;
            done_count++;
            written[cdb0_rd_phy] = 1'b1;
        end
    endtask

    // sampled mid-cycle away from the clock edge
    always @(negedge clk) begin
        if (rst) begin
            for (int p = 0; p < PHYS_REGS; p++) begin
                written[p] = (p == 0);
            end
            for (int n = 0; n < NUM_UOPS; n++) begin
                done[n] = 1'b0;
            end
            done_count    = 0;
            full_cycles   = 0;
            result_errors = 0;
        end else begin
            if (ds_valid && !ds_ready) full_cycles++;
            if (cdb0_valid) check_result();
            if (ext_wr_valid) written[ext_wr_phy] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int waited;
        int assert_errors;
        rng_state    = 32'ha9a6;
        rst          = 1'b1;
        ds_valid     = 1'b0;
        ds_rob_id    = '0;
        ds_rd_phy    = '0;
        ds_rs1_phy   = '0;
        ds_rs2_phy   = '0;
        ds_rs1_ready = 1'b0;
        ds_rs2_ready = 1'b0;
        ds_op1_sel   = OP1_RS1;
        ds_op2_sel   = OP2_RS2;
        ds_alu_op    = ALU_ADD;
        ds_imm       = '0;
        ds_pc        = '0;
        ext_wr_valid = 1'b0;
        ext_wr_phy   = '0;
        ext_wr_value = '0;
        other_errors = 0;
        timed_out    = 1'b0;
        for (int p = 0; p < PHYS_REGS; p++) begin
            model_reg[p] = '0;
        end
        for (int p = 1; p < 24; p++) begin
            model_reg[p] = next_rand();
        end
        build_program();

        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        if (ds_ready !== 1'b1) begin
            $display("[ERROR] %0t ds_ready: expected 1, got %b", $time, ds_ready);
            other_errors++;
        end

        for (int p = 1; p < 16; p++) begin
            ext_write(PHYS_IDX'(p));
        end

        fork
            begin
                for (int n = 0; n < NUM_UOPS; n++) begin
                    if (!timed_out) dispatch_uop(n);
                end
            end
            begin
                late_writes();
            end
        join

        waited = 0;
        while (done_count < NUM_UOPS && !timed_out) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_MAX) begin
                $display("timeout: only %0d of %0d uops completed", done_count, NUM_UOPS);
                timed_out = 1'b1;
            end
        end
        // drain so late stray broadcasts are still checked
        repeat (20) @(posedge clk);

        if (full_cycles == 0) begin
            $display("station never filled, ds_ready stayed high during dispatch");
            other_errors++;
        end
        assert_errors = u_int_exec_top.u_int_exec_properties.assert_failures;
        $display("result errors: %0d, other errors: %0d, assertion errors: %0d, completed: %0d of %0d",
                 result_errors, other_errors, assert_errors, done_count, NUM_UOPS);
        if (result_errors == 0 && other_errors == 0 && assert_errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
rtl/int_core_pkg.sv
rtl/int_rs.sv
rtl/phys_reg_file.sv
rtl/fu_alu.sv
rtl/int_exec_top.sv
sim/int_exec_properties.sv
sim/int_exec_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the issue cluster testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module int_exec_tb \
    -f verilog.f \
    -o int_exec_sim

./obj_dir/int_exec_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
